/* logic/xv_pkg.sv */
package xv_pkg;

   // operand select codes equal the position on the data bus
   localparam int N_W = 3;
   localparam logic [N_W-1:0] SEL_ZERO = 3'd0;
   localparam logic [N_W-1:0] SEL_IN_A = 3'd1;
   localparam logic [N_W-1:0] SEL_IN_B = 3'd2;
   localparam logic [N_W-1:0] SEL_ALU0 = 3'd3;
   localparam logic [N_W-1:0] SEL_ALU1 = 3'd4;
   localparam logic [N_W-1:0] SEL_MUL0 = 3'd5;
   localparam int N_SRC = int'(SEL_MUL0) + 1;

   // alu functions where slt max and min compare signed
   localparam int ALU_FNS_W = 3;
   localparam logic [ALU_FNS_W-1:0] ALU_ADD = 3'd0;
   localparam logic [ALU_FNS_W-1:0] ALU_SUB = 3'd1;
   localparam logic [ALU_FNS_W-1:0] ALU_AND = 3'd2;
   localparam logic [ALU_FNS_W-1:0] ALU_OR  = 3'd3;
   localparam logic [ALU_FNS_W-1:0] ALU_XOR = 3'd4;
   localparam logic [ALU_FNS_W-1:0] ALU_SLT = 3'd5;
   localparam logic [ALU_FNS_W-1:0] ALU_MAX = 3'd6;
   localparam logic [ALU_FNS_W-1:0] ALU_MIN = 3'd7;

   // configuration layout with alu0 in the top bits
   localparam int N_ALU = 2;
   localparam int ALU_CONF_BITS = 2*N_W + ALU_FNS_W;
   localparam int MUL_CONF_BITS = 2*N_W;
   localparam int CONF_BITS = N_ALU*ALU_CONF_BITS + MUL_CONF_BITS;
   localparam int CONF_ALU0_B = CONF_BITS - 1;
   localparam int CONF_MUL0_B = CONF_BITS - N_ALU*ALU_CONF_BITS - 1;

   // control port
   localparam int CONF_ADDR_W = 5;
   localparam int CTR_DATA_W = 8;

   localparam int CONF_ALU0 = 0;
   localparam int CONF_ALU1 = 4;
   localparam int ALU_CONF_OFFSET = 4;
   localparam int ALU_CONF_SELA = 0;
   localparam int ALU_CONF_SELB = 1;
   localparam int ALU_CONF_FNS = 2;
   localparam int CONF_MUL0 = 8;
   localparam int MUL_CONF_SELA = 0;
   localparam int MUL_CONF_SELB = 1;
   localparam int CONF_CLEAR = 16;
   localparam int CONF_SAVE = 17;
   localparam int CONF_LOAD = 18;

   // slot index width of at least one bit
   function automatic int slot_w(input int slots);
      return (slots > 1) ? $clog2(slots) : 1;
   endfunction

endpackage

/* logic/xv_ctrl.sv */
module xv_ctrl #(
   parameter int CONF_SLOTS = 4
) (
   input  logic                                 rst,
   input  logic                                 clk,
   input  logic                                 ctr_req,
   input  logic                                 ctr_we,
   input  logic [xv_pkg::CONF_ADDR_W-1:0]       ctr_addr,
   input  logic [xv_pkg::CTR_DATA_W-1:0]        ctr_wdata,
   output logic                                 ctr_ack,
   output logic [xv_pkg::CTR_DATA_W-1:0]        ctr_rdata,
   input  logic [xv_pkg::CTR_DATA_W-1:0]        fld_rdata,
   output logic                                 fld_we,
   output logic                                 clr,
   output logic [xv_pkg::CONF_ADDR_W-1:0]       fld_addr,
   output logic [xv_pkg::CTR_DATA_W-1:0]        fld_wdata,
   output logic                                 save,
   output logic                                 load,
   output logic [xv_pkg::slot_w(CONF_SLOTS)-1:0] slot
);

   localparam int SLOT_W = xv_pkg::slot_w(CONF_SLOTS);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT_LOAD,
      ST_ACK,
      ST_WAIT_REL
   } state_t;

   state_t state;
   logic   is_clr;
   logic   is_save;
   logic   is_load;

   // host holds address and data until ack
   assign fld_addr = ctr_addr;
   assign fld_wdata = ctr_wdata;
   assign slot = ctr_wdata[SLOT_W-1:0];

   assign is_clr = ctr_we && (int'(ctr_addr) == xv_pkg::CONF_CLEAR);
   assign is_save = ctr_we && (int'(ctr_addr) == xv_pkg::CONF_SAVE);
   assign is_load = ctr_we && (int'(ctr_addr) == xv_pkg::CONF_LOAD);

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         state <= ST_IDLE;
         ctr_ack <= 1'b0;
         fld_we <= 1'b0;
         clr <= 1'b0;
         save <= 1'b0;
         load <= 1'b0;
      end else begin
         fld_we <= 1'b0;
         clr <= 1'b0;
         save <= 1'b0;
         load <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (ctr_req) begin
                  fld_we <= ctr_we && !is_clr && !is_save && !is_load;
                  clr <= is_clr;
                  save <= is_save;
                  load <= is_load;
                  state <= is_load ? ST_WAIT_LOAD : ST_ACK;
               end
            end
            // slot memory read takes one more cycle
            ST_WAIT_LOAD: state <= ST_ACK;
            ST_ACK: begin
               ctr_ack <= 1'b1;
               state <= ST_WAIT_REL;
            end
            ST_WAIT_REL: begin
               if (!ctr_req) begin
                  ctr_ack <= 1'b0;
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge rst) begin
      if (state == ST_ACK) begin
         ctr_rdata <= fld_rdata;
      end
   end

endmodule

/* logic/xv_conf_reg.sv */
module xv_conf_reg (
   input  logic                             rst,
   input  logic                             clk,
   input  logic                             fld_we,
   input  logic                             clr,
   input  logic [xv_pkg::CONF_ADDR_W-1:0]   fld_addr,
   input  logic [xv_pkg::CTR_DATA_W-1:0]    fld_wdata,
   output logic [xv_pkg::CTR_DATA_W-1:0]    fld_rdata,
   input  logic                             conf_ld,
   input  logic [xv_pkg::CONF_BITS-1:0]     conf_in,
   output logic [xv_pkg::CONF_BITS-1:0]     conf_out
);

   logic [xv_pkg::CONF_BITS-1:0] conf_reg;
   int                           addr;

   // control address of one alu field
   function automatic int alu_fld(input int unit, input int fld);
      return xv_pkg::CONF_ALU0 + unit*xv_pkg::ALU_CONF_OFFSET + fld;
   endfunction

   // top bit of one alu configuration
   function automatic int alu_msb(input int unit);
      return xv_pkg::CONF_ALU0_B - unit*xv_pkg::ALU_CONF_BITS;
   endfunction

   assign addr = int'(fld_addr);
   assign conf_out = conf_reg;

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         conf_reg <= '0;
      end else if (conf_ld) begin
         conf_reg <= conf_in;
      end else if (clr) begin
         conf_reg <= '0;
      end else if (fld_we) begin
         for (int i = 0; i < xv_pkg::N_ALU; i++) begin
            if (addr == alu_fld(i, xv_pkg::ALU_CONF_SELA)) begin
               conf_reg[alu_msb(i) -: xv_pkg::N_W] <= fld_wdata[xv_pkg::N_W-1:0];
            end
            if (addr == alu_fld(i, xv_pkg::ALU_CONF_SELB)) begin
               conf_reg[alu_msb(i) - xv_pkg::N_W -: xv_pkg::N_W] <=
                  fld_wdata[xv_pkg::N_W-1:0];
            end
            if (addr == alu_fld(i, xv_pkg::ALU_CONF_FNS)) begin
               conf_reg[alu_msb(i) - 2*xv_pkg::N_W -: xv_pkg::ALU_FNS_W] <=
                  fld_wdata[xv_pkg::ALU_FNS_W-1:0];
            end
         end
         if (addr == xv_pkg::CONF_MUL0 + xv_pkg::MUL_CONF_SELA) begin
            conf_reg[xv_pkg::CONF_MUL0_B -: xv_pkg::N_W] <= fld_wdata[xv_pkg::N_W-1:0];
         end
         if (addr == xv_pkg::CONF_MUL0 + xv_pkg::MUL_CONF_SELB) begin
            conf_reg[xv_pkg::CONF_MUL0_B - xv_pkg::N_W -: xv_pkg::N_W] <=
               fld_wdata[xv_pkg::N_W-1:0];
         end
      end
   end

   // read back gives zero for unmapped addresses
   always_comb begin
      fld_rdata = '0;
      for (int i = 0; i < xv_pkg::N_ALU; i++) begin
         if (addr == alu_fld(i, xv_pkg::ALU_CONF_SELA)) begin
            fld_rdata[xv_pkg::N_W-1:0] = conf_reg[alu_msb(i) -: xv_pkg::N_W];
         end
         if (addr == alu_fld(i, xv_pkg::ALU_CONF_SELB)) begin
            fld_rdata[xv_pkg::N_W-1:0] = conf_reg[alu_msb(i) - xv_pkg::N_W -: xv_pkg::N_W];
         end
         if (addr == alu_fld(i, xv_pkg::ALU_CONF_FNS)) begin
            fld_rdata[xv_pkg::ALU_FNS_W-1:0] =
               conf_reg[alu_msb(i) - 2*xv_pkg::N_W -: xv_pkg::ALU_FNS_W];
         end
      end
      if (addr == xv_pkg::CONF_MUL0 + xv_pkg::MUL_CONF_SELA) begin
         fld_rdata[xv_pkg::N_W-1:0] = conf_reg[xv_pkg::CONF_MUL0_B -: xv_pkg::N_W];
      end
      if (addr == xv_pkg::CONF_MUL0 + xv_pkg::MUL_CONF_SELB) begin
         fld_rdata[xv_pkg::N_W-1:0] =
            conf_reg[xv_pkg::CONF_MUL0_B - xv_pkg::N_W -: xv_pkg::N_W];
      end
   end

endmodule

/* logic/xv_conf_mem.sv */
module xv_conf_mem #(
   parameter int CONF_SLOTS = 4
) (
   input  logic                                 rst,
   input  logic                                 clk,
   input  logic                                 save,
   input  logic                                 load,
   input  logic [xv_pkg::slot_w(CONF_SLOTS)-1:0] slot,
   input  logic [xv_pkg::CONF_BITS-1:0]         conf_cur,
   output logic                                 conf_ld,
   output logic [xv_pkg::CONF_BITS-1:0]         conf_in
);

   logic [xv_pkg::CONF_BITS-1:0] mem [CONF_SLOTS];

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         mem <= '{default: '0};
         conf_ld <= 1'b0;
      end else begin
         conf_ld <= load;
         if (save) begin
            mem[slot] <= conf_cur;
         end
      end
   end

   // slot contents ready together with conf_ld
   always_ff @(posedge rst) begin
      if (load) begin
         conf_in <= mem[slot];
      end
   end

endmodule

/* logic/xv_alu.sv */
module xv_alu #(
   parameter int DATA_W = 16
) (
   input  logic                              rst,
   input  logic                              clk,
   input  logic [xv_pkg::ALU_CONF_BITS-1:0]  conf,
   input  logic [xv_pkg::N_SRC*DATA_W-1:0]   data_bus,
   output logic [DATA_W-1:0]                 result
);

   logic [xv_pkg::N_W-1:0]       sel_a;
   logic [xv_pkg::N_W-1:0]       sel_b;
   logic [xv_pkg::ALU_FNS_W-1:0] fns;
   logic [DATA_W-1:0]            op_a;
   logic [DATA_W-1:0]            op_b;
   logic [DATA_W-1:0]            res_nxt;
   logic                         lt;

   assign sel_a = conf[xv_pkg::ALU_CONF_BITS-1 -: xv_pkg::N_W];
   assign sel_b = conf[xv_pkg::ALU_CONF_BITS-1-xv_pkg::N_W -: xv_pkg::N_W];
   assign fns = conf[xv_pkg::ALU_FNS_W-1:0];

   // codes past the bus read as zero
   always_comb begin
      op_a = '0;
      op_b = '0;
      if (sel_a <= xv_pkg::SEL_MUL0) begin
         op_a = data_bus[int'(sel_a)*DATA_W +: DATA_W];
      end
      if (sel_b <= xv_pkg::SEL_MUL0) begin
         op_b = data_bus[int'(sel_b)*DATA_W +: DATA_W];
      end
   end

   assign lt = $signed(op_a) < $signed(op_b);

   always_comb begin
      case (fns)
         xv_pkg::ALU_ADD: res_nxt = op_a + op_b;
         xv_pkg::ALU_SUB: res_nxt = op_a - op_b;
         xv_pkg::ALU_AND: res_nxt = op_a & op_b;
         xv_pkg::ALU_OR:  res_nxt = op_a | op_b;
         xv_pkg::ALU_XOR: res_nxt = op_a ^ op_b;
         xv_pkg::ALU_SLT: res_nxt = {{(DATA_W-1){1'b0}}, lt};
         xv_pkg::ALU_MAX: res_nxt = lt ? op_b : op_a;
         xv_pkg::ALU_MIN: res_nxt = lt ? op_a : op_b;
      endcase
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         result <= '0;
      end else begin
         result <= res_nxt;
      end
   end

endmodule

/* logic/xv_mul.sv */
module xv_mul #(
   parameter int DATA_W = 16
) (
   input  logic                              rst,
   input  logic                              clk,
   input  logic [xv_pkg::MUL_CONF_BITS-1:0]  conf,
   input  logic [xv_pkg::N_SRC*DATA_W-1:0]   data_bus,
   output logic [DATA_W-1:0]                 result
);

   logic [xv_pkg::N_W-1:0] sel_a;
   logic [xv_pkg::N_W-1:0] sel_b;
   logic [DATA_W-1:0]      op_a;
   logic [DATA_W-1:0]      op_b;

   assign sel_a = conf[xv_pkg::MUL_CONF_BITS-1 -: xv_pkg::N_W];
   assign sel_b = conf[xv_pkg::N_W-1:0];

   always_comb begin
      op_a = '0;
      op_b = '0;
      if (sel_a <= xv_pkg::SEL_MUL0) begin
         op_a = data_bus[int'(sel_a)*DATA_W +: DATA_W];
      end
      if (sel_b <= xv_pkg::SEL_MUL0) begin
         op_b = data_bus[int'(sel_b)*DATA_W +: DATA_W];
      end
   end

   // low half of the unsigned product
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         result <= '0;
      end else begin
         result <= op_a * op_b;
      end
   end

endmodule

/* logic/xv_top.sv */
module xv_top #(
   parameter int DATA_W = 16,
   parameter int CONF_SLOTS = 4
) (
   input  logic                             rst,
   input  logic                             clk,
   input  logic                             ctr_req,
   input  logic                             ctr_we,
   input  logic [xv_pkg::CONF_ADDR_W-1:0]   ctr_addr,
   input  logic [xv_pkg::CTR_DATA_W-1:0]    ctr_wdata,
   output logic                             ctr_ack,
   output logic [xv_pkg::CTR_DATA_W-1:0]    ctr_rdata,
   input  logic [DATA_W-1:0]                in_a,
   input  logic [DATA_W-1:0]                in_b,
   output logic [DATA_W-1:0]                alu0_out,
   output logic [DATA_W-1:0]                alu1_out,
   output logic [DATA_W-1:0]                mul0_out
);

   localparam int SLOT_W = xv_pkg::slot_w(CONF_SLOTS);

   logic                             fld_we;
   logic                             clr;
   logic [xv_pkg::CONF_ADDR_W-1:0]   fld_addr;
   logic [xv_pkg::CTR_DATA_W-1:0]    fld_wdata;
   logic [xv_pkg::CTR_DATA_W-1:0]    fld_rdata;
   logic                             save;
   logic                             load;
   logic [SLOT_W-1:0]                slot;
   logic                             conf_ld;
   logic [xv_pkg::CONF_BITS-1:0]     conf_in;
   logic [xv_pkg::CONF_BITS-1:0]     conf_out;
   logic [xv_pkg::N_SRC*DATA_W-1:0]  data_bus;

   // zero sits at position 0 to match the select codes
   assign data_bus = {mul0_out, alu1_out, alu0_out, in_b, in_a, {DATA_W{1'b0}}};

   xv_ctrl #(.CONF_SLOTS(CONF_SLOTS)) ctrl_i (
      .rst(rst), .clk(clk),
      .ctr_req(ctr_req), .ctr_we(ctr_we), .ctr_addr(ctr_addr), .ctr_wdata(ctr_wdata),
      .ctr_ack(ctr_ack), .ctr_rdata(ctr_rdata), .fld_rdata(fld_rdata),
      .fld_we(fld_we), .clr(clr), .fld_addr(fld_addr), .fld_wdata(fld_wdata),
      .save(save), .load(load), .slot(slot)
   );

   xv_conf_reg conf_reg_i (
      .rst(rst), .clk(clk),
      .fld_we(fld_we), .clr(clr), .fld_addr(fld_addr), .fld_wdata(fld_wdata),
      .fld_rdata(fld_rdata), .conf_ld(conf_ld), .conf_in(conf_in), .conf_out(conf_out)
   );

   xv_conf_mem #(.CONF_SLOTS(CONF_SLOTS)) conf_mem_i (
      .rst(rst), .clk(clk),
      .save(save), .load(load), .slot(slot), .conf_cur(conf_out),
      .conf_ld(conf_ld), .conf_in(conf_in)
   );

   xv_alu #(.DATA_W(DATA_W)) alu0_i (
      .rst(rst), .clk(clk),
      .conf(conf_out[xv_pkg::CONF_ALU0_B -: xv_pkg::ALU_CONF_BITS]),
      .data_bus(data_bus), .result(alu0_out)
   );

   xv_alu #(.DATA_W(DATA_W)) alu1_i (
      .rst(rst), .clk(clk),
      .conf(conf_out[xv_pkg::CONF_ALU0_B - xv_pkg::ALU_CONF_BITS -: xv_pkg::ALU_CONF_BITS]),
      .data_bus(data_bus), .result(alu1_out)
   );

   xv_mul #(.DATA_W(DATA_W)) mul0_i (
      .rst(rst), .clk(clk),
      .conf(conf_out[xv_pkg::CONF_MUL0_B -: xv_pkg::MUL_CONF_BITS]),
      .data_bus(data_bus), .result(mul0_out)
   );

endmodule

/* dv/xv_top_props.sv */
module xv_top_props (
   input logic rst,
   input logic clk,
   input logic ctr_req,
   input logic ctr_ack,
   input logic load,
   input logic conf_ld
);
   timeunit 1ns;
   timeprecision 1ps;

   // ack only answers a pending request
   ack_rise_with_req: assert property (@(posedge rst) disable iff (clk)
      $rose(ctr_ack) |-> $past(ctr_req))
      else $error("ctr_ack rose without ctr_req");

   ack_fall_after_release: assert property (@(posedge rst) disable iff (clk)
      $fell(ctr_ack) |-> !$past(ctr_req))
      else $error("ctr_ack fell while ctr_req was still high");

   // slot read takes exactly one cycle
   ld_after_load: assert property (@(posedge rst) disable iff (clk)
      load |=> conf_ld)
      else $error("conf_ld missing one cycle after load");

   ld_only_after_load: assert property (@(posedge rst) disable iff (clk)
      conf_ld |-> $past(load))
      else $error("conf_ld without a load one cycle before");

endmodule

bind xv_top xv_top_props props_i (
   .rst(rst), .clk(clk),
   .ctr_req(ctr_req), .ctr_ack(ctr_ack),
   .load(load), .conf_ld(conf_ld)
);

/* dv/xv_tb.sv */
module xv_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int DATA_W = 16;
   localparam int CONF_SLOTS = 4;
   localparam int CLK_PERIOD = 8;
   localparam int HS_TIMEOUT = 20;
   localparam int CYCLES_PER_CASE = 40;
   localparam CASES_FILE = "dv/xv_cases.txt";

   logic                            rst;
   logic                            clk;
   logic                            ctr_req;
   logic                            ctr_we;
   logic [xv_pkg::CONF_ADDR_W-1:0]  ctr_addr;
   logic [xv_pkg::CTR_DATA_W-1:0]   ctr_wdata;
   logic                            ctr_ack;
   logic [xv_pkg::CTR_DATA_W-1:0]   ctr_rdata;
   logic [DATA_W-1:0]               in_a;
   logic [DATA_W-1:0]               in_b;
   logic [DATA_W-1:0]               alu0_out;
   logic [DATA_W-1:0]               alu1_out;
   logic [DATA_W-1:0]               mul0_out;

   logic [15:0] lfsr_state;
   int          errors;
   int          n_cases;

   xv_top #(.DATA_W(DATA_W), .CONF_SLOTS(CONF_SLOTS)) xv_top_i (
      .rst(rst), .clk(clk),
      .ctr_req(ctr_req), .ctr_we(ctr_we), .ctr_addr(ctr_addr), .ctr_wdata(ctr_wdata),
      .ctr_ack(ctr_ack), .ctr_rdata(ctr_rdata),
      .in_a(in_a), .in_b(in_b),
      .alu0_out(alu0_out), .alu1_out(alu1_out), .mul0_out(mul0_out)
   );

   // rst is the clock of this design
   initial begin
      rst = 1'b0;
      forever #(CLK_PERIOD/2) rst = ~rst;
   end

   // taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic next_cycle();
      @(posedge rst);
      #1;
   endtask

   // 0 to 3 idle cycles from two lfsr bits
   task automatic idle_gap();
      int gap;
      gap = 0;
      for (int i = 0; i < 2; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         gap = gap*2 + int'(lfsr_state[0]);
      end
      repeat (gap) next_cycle();
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_ctr(input string name, input logic [xv_pkg::CTR_DATA_W-1:0] exp,
                            input logic [xv_pkg::CTR_DATA_W-1:0] act);
      if (act !== exp) begin
         $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   // one full four-phase transfer
   task automatic ctr_access(input logic we, input logic [xv_pkg::CONF_ADDR_W-1:0] addr,
                             input logic [xv_pkg::CTR_DATA_W-1:0] wdata,
                             output logic [xv_pkg::CTR_DATA_W-1:0] rdata);
      int cnt;
      idle_gap();
      ctr_we = we;
      ctr_addr = addr;
      ctr_wdata = wdata;
      ctr_req = 1'b1;
      cnt = 0;
      while (ctr_ack !== 1'b1 && cnt < HS_TIMEOUT) begin
         next_cycle();
         cnt++;
      end
      rdata = ctr_rdata;
      if (ctr_ack !== 1'b1) begin
         $display("no ack within %0d cycles for address %h", HS_TIMEOUT, addr);
         errors++;
      end
      idle_gap();
      ctr_req = 1'b0;
      cnt = 0;
      while (ctr_ack !== 1'b0 && cnt < HS_TIMEOUT) begin
         next_cycle();
         cnt++;
      end
      if (ctr_ack !== 1'b0) begin
         $display("ack still high %0d cycles after the request was dropped", HS_TIMEOUT);
         errors++;
      end
   endtask

   task automatic count_cases();
      int         fd;
      int         r;
      logic [7:0] op;
      string      line;
      fd = $fopen(CASES_FILE, "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            r = $fscanf(fd, " %c", op);
            if (r == 1) begin
               r = $fgets(line, fd);
               if (op != "#") begin
                  n_cases++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin : main_seq
      int                            fd;
      int                            r;
      int                            nargs;
      int                            n_run;
      int                            n_ok;
      int                            errs_before;
      logic [7:0]                    op;
      logic [31:0]                   a;
      logic [31:0]                   b;
      logic [31:0]                   c;
      logic [xv_pkg::CTR_DATA_W-1:0] rdata;
      string                         line;

      clk = 1'b1;
      ctr_req = 1'b0;
      ctr_we = 1'b0;
      ctr_addr = '0;
      ctr_wdata = '0;
      in_a = '0;
      in_b = '0;
      lfsr_state = 16'd25;
      errors = 0;
      n_run = 0;
      n_ok = 0;
      count_cases();
      repeat (5) @(posedge rst);
      #1;
      clk = 1'b0;

      fd = $fopen(CASES_FILE, "r");
      if (fd == 0) begin
         $display("could not open %s", CASES_FILE);
         errors++;
      end else begin
         while (!$feof(fd)) begin
            r = $fscanf(fd, " %c", op);
            if (r == 1 && op == "#") begin
               r = $fgets(line, fd);
            end else if (r == 1) begin
               errs_before = errors;
               nargs = 2;
               case (op)
                  "W": begin
                     r = $fscanf(fd, "%h %h", a, b);
                     ctr_access(1'b1, a[xv_pkg::CONF_ADDR_W-1:0],
                                b[xv_pkg::CTR_DATA_W-1:0], rdata);
                  end
                  "R": begin
                     r = $fscanf(fd, "%h %h", a, b);
                     ctr_access(1'b0, a[xv_pkg::CONF_ADDR_W-1:0], '0, rdata);
                     check_ctr("ctr_rdata", b[xv_pkg::CTR_DATA_W-1:0], rdata);
                  end
                  "I": begin
                     r = $fscanf(fd, "%h %h", a, b);
                     in_a = a[DATA_W-1:0];
                     in_b = b[DATA_W-1:0];
                  end
                  "C": begin
                     nargs = 3;
                     r = $fscanf(fd, "%h %h %h", a, b, c);
                     repeat (4) next_cycle();
                     check_data("alu0_out", a[DATA_W-1:0], alu0_out);
                     check_data("alu1_out", b[DATA_W-1:0], alu1_out);
                     check_data("mul0_out", c[DATA_W-1:0], mul0_out);
                  end
                  default: begin
                     r = $fgets(line, fd);
                     r = nargs;
                     $display("unknown operation %c in the cases file", op);
                     errors++;
                  end
               endcase
               if (r != nargs) begin
                  $display("case %0d has missing or malformed values", n_run + 1);
                  errors++;
               end
               n_run++;
               if (errors == errs_before) begin
                  n_ok++;
                  $display("case %0d (%c) ok", n_run, op);
               end else begin
                  $display("case %0d (%c) failed", n_run, op);
               end
            end
         end
         $fclose(fd);
      end

      $display("%0d of %0d cases ok, %0d errors", n_ok, n_run, errors);
      if (errors == 0 && n_run > 0 && n_run == n_cases) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      wait (n_cases > 0);
      repeat (5 + CYCLES_PER_CASE * n_cases) @(posedge rst);
      $display("run took longer than %0d cycles per case and was stopped", CYCLES_PER_CASE);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* dv/xv_cases.txt */
# W addr data : control write        R addr data : control read, expected data
# I in_a in_b : set inputs           C alu0 alu1 mul0 : expected outputs after four cycles
# all values hex
C 0000 0000 0000
R 00 00
R 09 00
W 00 0d
R 00 05
W 06 fa
R 06 02
W 09 0b
R 09 03
R 03 00
W 0c 07
R 0c 00
R 13 00
W 10 00
R 00 00
I 8003 0005
W 00 01
W 01 02
W 04 02
W 05 01
W 08 01
W 09 02
C 8008 8008 800f
W 02 01
W 06 01
C 7ffe 8002 800f
W 02 02
W 06 03
C 0001 8007 800f
W 02 04
W 06 05
C 8006 0000 800f
W 02 05
W 06 06
C 0001 0005 800f
W 02 06
W 06 07
C 0005 8003 800f
I ffff 0003
W 02 00
C 0002 ffff fffd
I 0007 0003
W 02 01
W 04 03
W 05 02
W 06 00
W 08 04
W 09 01
C 0004 0007 0031
W 11 02
W 02 02
W 06 04
C 0003 0000 0000
R 02 02
W 12 02
R 02 01
R 06 00
R 04 03
C 0004 0007 0031
W 10 00
C 0000 0000 0000
R 04 00
R 09 00

/* vlog.f */
logic/xv_pkg.sv
logic/xv_ctrl.sv
logic/xv_conf_reg.sv
logic/xv_conf_mem.sv
logic/xv_alu.sv
logic/xv_mul.sv
logic/xv_top.sv
dv/xv_top_props.sv
dv/xv_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module xv_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

out=$(./obj_dir/Vxv_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
   exit 0
fi
exit 1
